// File: sim.f
+incdir+.
jtag_pkg.sv
jtag_tap_fsm.sv
jtag_ir.sv
jtag_user_reg.sv
jtag_tdo_path.sv
jtag_tap_top.sv
jtag_tap_asserts.sv
tb_jtag_tap.sv

// File: tb_jtag_tap.sv
`timescale 1ns/1ps
`default_nettype none

`include "jtag_cfg.svh"

module tb_jtag_tap;

  import jtag_pkg::*;

  localparam int N_SCANS    = 27;   // Checked IR and DR scans
  localparam int TIMEOUT_NS = N_SCANS * (`JTAG_IR_LEN + 32 + 20) * 8 * 2;

  logic                          tck_i;
  logic                          rst_ni;
  logic                          tms_i;
  logic                          td_i;
  logic                          td_o;
  user_data_t [`JTAG_N_USER-1:0] user_data;   // Parallel outs of the DUT

  logic [`JTAG_IR_LEN-1:0] ir_cur;                 // Instruction the TAP should hold
  user_data_t              model [`JTAG_N_USER];   // Expected update stages
  logic [31:0]             lfsr_q;
  logic [31:0]             exp_q [$];              // Expected scan results
  logic [31:0]             got_q [$];              // Collected scan results
  int                      n_checked;
  event                    scan_done;

  always #4 tck_i = ~tck_i;   // 8 ns period

  jtag_tap_top i_dut (
    .tck_i       (tck_i),
    .rst_ni      (rst_ni),
    .tms_i       (tms_i),
    .td_i        (td_i),
    .td_o        (td_o),
    .user_data_o (user_data)
  );

  // x^32 + x^22 + x^2 + x + 1, feedback into the LSB
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v[i]   = lfsr_q[0];
    end
  endtask

  // Value a scan should shift out, LSB first
  function automatic logic [31:0] expected_scan(
    input logic                    is_ir,
    input logic [`JTAG_IR_LEN-1:0] instr,
    input int                      len,
    input logic [31:0]             din
  );
    logic [31:0] mask;
    logic [31:0] val;
    int          k;
    mask = (len >= 32) ? '1 : ((32'd1 << len) - 32'd1);
    k    = int'(instr) - int'(`JTAG_INSTR_USER_BASE);
    val  = '0;
    if (is_ir)
      val = `JTAG_IR_CAPTURE;                 // Capture pattern, whatever goes in
    else if (instr == `JTAG_INSTR_IDCODE)
      val = `JTAG_IDCODE_VALUE;
    else if (k >= 0 && k < `JTAG_N_USER)
      val[`JTAG_USER_W-1:0] = model[k];       // Last written byte
    else
      val = din << 1;                         // Bypass, also undefined codes
    return val & mask;
  endfunction

  // One TCK cycle, entered and left 1 ns after the rising edge
  task automatic clock_bit(input logic tms, input logic tdi, output logic tdo);
    tms_i = tms;
    td_i  = tdi;
    @(negedge tck_i);
    #3;             // Just before the next rising edge
    tdo = td_o;
    @(posedge tck_i);
    #1;
  endtask

  // TMS sequence, LSB first, TDI held low
  task automatic walk_tms(input logic [7:0] seq, input int n);
    logic unused_tdo;
    for (int i = 0; i < n; i++)
      clock_bit(seq[i], 1'b0, unused_tdo);
  endtask

  // Full scan from Run-Test/Idle back to Run-Test/Idle
  task automatic scan(input logic is_ir, input int len, input logic [31:0] din,
                      output logic [31:0] dout);
    logic b;
    dout = '0;
    if (is_ir)
      walk_tms(8'b0000_0011, 4);   // Select-DR, Select-IR, Capture-IR, Shift-IR
    else
      walk_tms(8'b0000_0001, 3);   // Select-DR, Capture-DR, Shift-DR
    for (int i = 0; i < len; i++)
    begin
      clock_bit(i == len - 1, din[i], b);   // Last bit leaves to Exit1
      dout[i] = b;
    end
    walk_tms(8'b0000_0001, 2);     // Update, Run-Test/Idle
  endtask

  task automatic check_ir(input logic [`JTAG_IR_LEN-1:0] instr);
    logic [31:0] din;
    logic [31:0] dout;
    din                    = '0;
    din[`JTAG_IR_LEN-1:0]  = instr;
    exp_q.push_back(expected_scan(1'b1, ir_cur, `JTAG_IR_LEN, din));
    scan(1'b1, `JTAG_IR_LEN, din, dout);
    ir_cur = instr;                // Latched on Update-IR
    got_q.push_back(dout);
    -> scan_done;
  endtask

  task automatic check_dr(input int len);
    logic [31:0] din;
    logic [31:0] dout;
    int          k;
    take_bits(len, din);
    exp_q.push_back(expected_scan(1'b0, ir_cur, len, din));
    scan(1'b0, len, din, dout);
    k = int'(ir_cur) - int'(`JTAG_INSTR_USER_BASE);
    if (k >= 0 && k < `JTAG_N_USER)
      model[k] = din[`JTAG_USER_W-1:0];   // Update-DR took the new byte
    got_q.push_back(dout);
    -> scan_done;
  endtask

  // Five ones reach Test-Logic-Reset from anywhere, one zero to idle
  task automatic goto_reset();
    walk_tms(8'b0001_1111, 6);
    ir_cur = `JTAG_INSTR_IDCODE;
  endtask

  initial
  begin : stimulus
    logic [`JTAG_IR_LEN-1:0] code;
    tck_i     = 1'b0;
    rst_ni    = 1'b0;
    tms_i     = 1'b1;
    td_i      = 1'b0;
    lfsr_q    = 32'd73387;
    ir_cur    = `JTAG_INSTR_IDCODE;
    n_checked = 0;
    for (int k = 0; k < `JTAG_N_USER; k++)
      model[k] = '0;
    repeat (2) @(posedge tck_i);
    #1;
    rst_ni = 1'b1;
    walk_tms(8'b0, 1);               // To Run-Test/Idle

    check_dr(32);                    // IDCODE without any IR scan

    check_ir(`JTAG_INSTR_BYPASS);
    check_dr(16);
    check_ir(4'b0011);               // Undefined code
    check_dr(12);

    // Write each user reg, then read back while writing again
    code = `JTAG_INSTR_USER_BASE;
    for (int k = 0; k < `JTAG_N_USER; k++)
    begin
      check_ir(code);
      check_dr(`JTAG_USER_W);
      check_dr(`JTAG_USER_W);
      code = code + 1'b1;
    end

    goto_reset();                    // From Run-Test/Idle
    check_dr(32);

    check_ir(`JTAG_INSTR_USER_BASE | 4'b0010);
    walk_tms(8'b0000_0001, 2);       // Sit in Capture-DR of user reg 2
    goto_reset();                    // Update-DR writes back the captured value
    check_dr(32);

    walk_tms(8'b0000_0011, 4);
    walk_tms(8'b0, 2);               // Halfway through Shift-IR
    goto_reset();
    check_dr(32);

    @(posedge tck_i);
    #1;
    if (n_checked == N_SCANS)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("[ERROR] %0t: %0d of %0d scans checked", $time, n_checked, N_SCANS);
      $display("Test failed");
      $fatal(1, "Scan count mismatch");
    end
  end

  // Scan results and all parallel outs after every scan
  initial
  begin : compare
    logic [31:0] exp_v;
    logic [31:0] got_v;
    forever
    begin
      @(scan_done);
      while (got_q.size() > 0)
      begin
        exp_v = exp_q.pop_front();
        got_v = got_q.pop_front();
        assert (got_v === exp_v)
        else
        begin
          $display("[ERROR] %0t: scan %0d shifted out %h, expected %h",
                   $time, n_checked, got_v, exp_v);
          $display("Test failed");
          $fatal(1, "Scan mismatch");
        end
        n_checked++;
      end
      for (int k = 0; k < `JTAG_N_USER; k++)
      begin
        assert (user_data[k] === model[k])
        else
        begin
          $display("[ERROR] %0t: user_data_o[%0d] is %h, expected %h",
                   $time, k, user_data[k], model[k]);
          $display("Test failed");
          $fatal(1, "User output mismatch");
        end
      end
    end
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the scans did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: jtag_tap_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "jtag_cfg.svh"

module jtag_tap_asserts (
  input logic                                    tck_i,
  input logic                                    rst_ni,
  input jtag_pkg::dr_ctrl_t                      dr_ctrl_i,
  input logic                                    capture_ir_i,
  input logic                                    shift_ir_i,
  input logic                                    update_ir_i,
  input jtag_pkg::dr_sel_t                       dr_sel_i,
  input jtag_pkg::user_data_t [`JTAG_N_USER-1:0] user_data_i
);

  // One TAP state at a time, so at most one strobe
  a_one_strobe: assert property (@(posedge tck_i) disable iff (!rst_ni)
    $onehot0({dr_ctrl_i, capture_ir_i, shift_ir_i, update_ir_i}))
  else
    $error("Capture, shift and update strobes overlap");

  // Decoded selects stay one-hot
  a_one_select: assert property (@(posedge tck_i) disable iff (!rst_ni)
    $onehot0({dr_sel_i.idcode_sel, dr_sel_i.bypass_sel, dr_sel_i.user_sel}))
  else
    $error("More than one data register selected");

  // Parallel outs move only on the edge leaving Update-DR
  a_update_only: assert property (@(posedge tck_i) disable iff (!rst_ni)
    !$stable(user_data_i) |-> $past(dr_ctrl_i.update_dr))
  else
    $error("user_data_o changed outside Update-DR");

endmodule

bind jtag_tap_top jtag_tap_asserts i_asserts (
  .tck_i        (tck_i),
  .rst_ni       (rst_ni),
  .dr_ctrl_i    (dr_ctrl),
  .capture_ir_i (capture_ir),
  .shift_ir_i   (shift_ir),
  .update_ir_i  (update_ir),
  .dr_sel_i     (dr_sel),
  .user_data_i  (user_data_o)
);

`default_nettype wire

// File: jtag_tap_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "jtag_cfg.svh"

module jtag_tap_top (
  input  logic                                    tck_i,
  input  logic                                    rst_ni,
  input  logic                                    tms_i,
  input  logic                                    td_i,
  output logic                                    td_o,
  output jtag_pkg::user_data_t [`JTAG_N_USER-1:0] user_data_o   // Parallel outs
);

  import jtag_pkg::*;

  dr_ctrl_t                dr_ctrl;       // DR strobes to every DR
  dr_sel_t                 dr_sel;        // Instruction selects
  logic                    capture_ir;
  logic                    shift_ir;
  logic                    update_ir;
  logic                    reset_state;
  logic                    ir_tdo;
  logic [`JTAG_N_USER-1:0] user_tdo;      // Serial outs of user regs

  // TAP controller
  jtag_tap_fsm i_tap_fsm (
    .tck_i         (tck_i),
    .rst_ni        (rst_ni),
    .tms_i         (tms_i),
    .dr_ctrl_o     (dr_ctrl),
    .capture_ir_o  (capture_ir),
    .shift_ir_o    (shift_ir),
    .update_ir_o   (update_ir),
    .reset_state_o (reset_state)
  );

  // Instruction register and decode
  jtag_ir i_ir (
    .tck_i         (tck_i),
    .rst_ni        (rst_ni),
    .td_i          (td_i),
    .capture_ir_i  (capture_ir),
    .shift_ir_i    (shift_ir),
    .update_ir_i   (update_ir),
    .reset_state_i (reset_state),
    .dr_sel_o      (dr_sel),
    .ir_tdo_o      (ir_tdo)
  );

  // User data registers, all on the same td_i
  for (genvar k = 0; k < `JTAG_N_USER; k++)
  begin : g_user_reg
    jtag_user_reg i_user_reg (
      .tck_i       (tck_i),
      .rst_ni      (rst_ni),
      .td_i        (td_i),
      .sel_i       (dr_sel.user_sel[k]),
      .dr_ctrl_i   (dr_ctrl),
      .tdo_o       (user_tdo[k]),
      .user_data_o (user_data_o[k])
    );
  end

  // IDCODE, bypass and td_o retiming
  jtag_tdo_path i_tdo_path (
    .tck_i      (tck_i),
    .rst_ni     (rst_ni),
    .td_i       (td_i),
    .dr_ctrl_i  (dr_ctrl),
    .shift_ir_i (shift_ir),
    .dr_sel_i   (dr_sel),
    .ir_tdo_i   (ir_tdo),
    .user_tdo_i (user_tdo),
    .td_o       (td_o)
  );

endmodule

`default_nettype wire

// File: jtag_tdo_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "jtag_cfg.svh"

module jtag_tdo_path (
  input  logic                    tck_i,
  input  logic                    rst_ni,
  input  logic                    td_i,
  input  jtag_pkg::dr_ctrl_t      dr_ctrl_i,
  input  logic                    shift_ir_i,
  input  jtag_pkg::dr_sel_t       dr_sel_i,
  input  logic                    ir_tdo_i,     // IR serial out
  input  logic [`JTAG_N_USER-1:0] user_tdo_i,   // One serial out per user reg
  output logic                    td_o
);

  import jtag_pkg::*;

  logic [31:0] idcode_q;   // IDCODE shift register
  logic        bypass_q;   // Single-bit bypass
  user_sel_t   user_hit;   // Serial out of the selected user reg
  logic        dr_tdo;     // Selected DR serial out
  logic        tdo_d;      // Next td_o

  // IDCODE reloads whenever it is not shifting
  always_ff @(posedge tck_i)
  begin
    if (dr_sel_i.idcode_sel && dr_ctrl_i.shift_dr)
      idcode_q <= {td_i, idcode_q[31:1]};
    else
      idcode_q <= `JTAG_IDCODE_VALUE;
  end

  // Bypass captures 0, then delays td_i by one bit
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bypass_q <= 1'b0;
    else if (dr_sel_i.bypass_sel)
    begin
      if (dr_ctrl_i.capture_dr)
        bypass_q <= 1'b0;
      else if (dr_ctrl_i.shift_dr)
        bypass_q <= td_i;
    end
  end

  // Selects are one-hot, so an OR of masked outs is enough
  assign user_hit = dr_sel_i.user_sel & user_tdo_i;

  // DR source by instruction select
  always_comb
  begin
    if (dr_sel_i.idcode_sel)
      dr_tdo = idcode_q[0];
    else if (dr_sel_i.bypass_sel)
      dr_tdo = bypass_q;
    else
      dr_tdo = |user_hit;
  end

  // IR wins while in Shift-IR
  assign tdo_d = shift_ir_i ? ir_tdo_i : dr_tdo;

  // Retimed on the falling edge, state and selects seen at that edge
  always_ff @(negedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      td_o <= 1'b0;
    else
      td_o <= tdo_d;
  end

  // Output enable is not modelled, td_o is always driven

endmodule

`default_nettype wire

// File: jtag_user_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "jtag_cfg.svh"

module jtag_user_reg (
  input  logic                 tck_i,
  input  logic                 rst_ni,
  input  logic                 td_i,
  input  logic                 sel_i,         // From the IR decode
  input  jtag_pkg::dr_ctrl_t   dr_ctrl_i,
  output logic                 tdo_o,
  output jtag_pkg::user_data_t user_data_o    // Update stage, parallel out
);

  import jtag_pkg::*;

  user_data_t shift_q;   // Shift stage

  // Capture reloads the update value so a write reads back
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      shift_q <= '0;
    else if (sel_i)
    begin
      if (dr_ctrl_i.capture_dr)
        shift_q <= user_data_o;
      else if (dr_ctrl_i.shift_dr)
        shift_q <= {td_i, shift_q[`JTAG_USER_W-1:1]};   // LSB first
    end
  end

  assign tdo_o = shift_q[0];

  // Update stage, changes only on Update-DR of this register
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      user_data_o <= '0;
    else if (sel_i && dr_ctrl_i.update_dr)
      user_data_o <= shift_q;
  end

endmodule

`default_nettype wire

// File: jtag_ir.sv
`timescale 1ns/1ps
`default_nettype none

`include "jtag_cfg.svh"

module jtag_ir (
  input  logic              tck_i,
  input  logic              rst_ni,
  input  logic              td_i,
  input  logic              capture_ir_i,
  input  logic              shift_ir_i,
  input  logic              update_ir_i,
  input  logic              reset_state_i,   // Test-Logic-Reset
  output jtag_pkg::dr_sel_t dr_sel_o,
  output logic              ir_tdo_o
);

  import jtag_pkg::*;

  ir_t       shift_q;    // Shift stage
  ir_t       instr_q;    // Latched instruction
  user_sel_t user_hit;   // Latched code matches a user reg

  // Capture and shift, LSB leaves first
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      shift_q <= '0;
    else if (capture_ir_i)
      shift_q <= `JTAG_IR_CAPTURE;
    else if (shift_ir_i)
      shift_q <= {td_i, shift_q[`JTAG_IR_LEN-1:1]};
  end

  assign ir_tdo_o = shift_q[0];

  // Instruction latch, IDCODE after reset
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      instr_q <= `JTAG_INSTR_IDCODE;
    else if (reset_state_i)
      instr_q <= `JTAG_INSTR_IDCODE;   // Test-Logic-Reset wins over update
    else if (update_ir_i)
      instr_q <= shift_q;
  end

  // User codes are consecutive from the base code
  always_comb
  begin
    user_hit = '0;
    for (int k = 0; k < `JTAG_N_USER; k++)
      user_hit[k] = (instr_q == ir_t'(`JTAG_INSTR_USER_BASE + k));
  end

  // One-hot selects
  always_comb
  begin
    dr_sel_o = '0;
    case (instr_q)
      `JTAG_INSTR_IDCODE: dr_sel_o.idcode_sel = 1'b1;
      `JTAG_INSTR_BYPASS: dr_sel_o.bypass_sel = 1'b1;
      default:
      begin
        if (|user_hit)
          dr_sel_o.user_sel = user_hit;
        else
          dr_sel_o.bypass_sel = 1'b1;   // Undefined code acts as BYPASS
      end
    endcase
  end

endmodule

`default_nettype wire

// File: jtag_tap_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_tap_fsm (
  input  logic               tck_i,
  input  logic               rst_ni,
  input  logic               tms_i,
  output jtag_pkg::dr_ctrl_t dr_ctrl_o,      // DR capture, shift, update
  output logic               capture_ir_o,
  output logic               shift_ir_o,
  output logic               update_ir_o,
  output logic               reset_state_o   // In Test-Logic-Reset
);

  import jtag_pkg::*;

  tap_state_e state_q;
  tap_state_e state_d;

  // Standard TMS transition table
  always_comb
  begin
    case (state_q)
      st_test_logic_reset: state_d = tms_i ? st_test_logic_reset : st_run_test_idle;
      st_run_test_idle:    state_d = tms_i ? st_select_dr_scan : st_run_test_idle;

      // DR column
      st_select_dr_scan:   state_d = tms_i ? st_select_ir_scan : st_capture_dr;
      st_capture_dr:       state_d = tms_i ? st_exit1_dr : st_shift_dr;
      st_shift_dr:         state_d = tms_i ? st_exit1_dr : st_shift_dr;
      st_exit1_dr:         state_d = tms_i ? st_update_dr : st_pause_dr;
      st_pause_dr:         state_d = tms_i ? st_exit2_dr : st_pause_dr;
      st_exit2_dr:         state_d = tms_i ? st_update_dr : st_shift_dr;
      st_update_dr:        state_d = tms_i ? st_select_dr_scan : st_run_test_idle;

      // IR column
      st_select_ir_scan:   state_d = tms_i ? st_test_logic_reset : st_capture_ir;
      st_capture_ir:       state_d = tms_i ? st_exit1_ir : st_shift_ir;
      st_shift_ir:         state_d = tms_i ? st_exit1_ir : st_shift_ir;
      st_exit1_ir:         state_d = tms_i ? st_update_ir : st_pause_ir;
      st_pause_ir:         state_d = tms_i ? st_exit2_ir : st_pause_ir;
      st_exit2_ir:         state_d = tms_i ? st_update_ir : st_shift_ir;
      st_update_ir:        state_d = tms_i ? st_select_dr_scan : st_run_test_idle;

      default:             state_d = st_test_logic_reset;   // Unreachable
    endcase
  end

  // State register, reset lands in Test-Logic-Reset
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= st_test_logic_reset;
    else
      state_q <= state_d;
  end

  // Strobes straight from the current state, no latency
  assign dr_ctrl_o.capture_dr = (state_q == st_capture_dr);
  assign dr_ctrl_o.shift_dr   = (state_q == st_shift_dr);
  assign dr_ctrl_o.update_dr  = (state_q == st_update_dr);

  assign capture_ir_o  = (state_q == st_capture_ir);
  assign shift_ir_o    = (state_q == st_shift_ir);
  assign update_ir_o   = (state_q == st_update_ir);
  assign reset_state_o = (state_q == st_test_logic_reset);   // Forces IDCODE in IR

  // Five TMS ones from any state end in Test-Logic-Reset,
  // so no separate TMS history is kept here

endmodule

`default_nettype wire

// File: jtag_pkg.sv
`default_nettype none

`include "jtag_cfg.svh"

package jtag_pkg;

  // TAP states, IEEE 1149.1 style encoding
  typedef enum logic [3:0] {
    st_exit2_dr         = 4'h0,
    st_exit1_dr         = 4'h1,
    st_shift_dr         = 4'h2,
    st_pause_dr         = 4'h3,
    st_select_ir_scan   = 4'h4,
    st_update_dr        = 4'h5,
    st_capture_dr       = 4'h6,
    st_select_dr_scan   = 4'h7,
    st_exit2_ir         = 4'h8,
    st_exit1_ir         = 4'h9,
    st_shift_ir         = 4'ha,
    st_pause_ir         = 4'hb,
    st_run_test_idle    = 4'hc,
    st_update_ir        = 4'hd,
    st_capture_ir       = 4'he,
    st_test_logic_reset = 4'hf
  } tap_state_e;

  typedef logic [`JTAG_IR_LEN-1:0] ir_t;        // One instruction
  typedef logic [`JTAG_USER_W-1:0] user_data_t; // One user register value
  typedef logic [`JTAG_N_USER-1:0] user_sel_t;  // One-hot user select

  // DR-side strobes from the TAP FSM
  typedef struct packed {
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
  } dr_ctrl_t;

  // Data register selects from the decoded instruction
  typedef struct packed {
    logic      idcode_sel;
    logic      bypass_sel;
    user_sel_t user_sel;
  } dr_sel_t;

endpackage

`default_nettype wire

// File: jtag_cfg.svh
`ifndef JTAG_CFG_SVH
`define JTAG_CFG_SVH

// Instruction register
`define JTAG_IR_LEN 4
`define JTAG_IR_CAPTURE 4'b0101        // Fixed capture pattern, easy to spot on td_o

// Instruction codes
`define JTAG_INSTR_IDCODE 4'b0010
`define JTAG_INSTR_BYPASS 4'b1111
`define JTAG_INSTR_USER_BASE 4'b0100   // User reg k at base + k

// Identification value
// Version 1, part 0x4951, manufacturer 0x0e1, LSB fixed to 1
`define JTAG_IDCODE_VALUE 32'h149511c3

// User data registers
`define JTAG_N_USER 6
`define JTAG_USER_W 8

`endif
